//--- verilog/hid_consts.svh
`ifndef HID_CONSTS_SVH
`define HID_CONSTS_SVH

// ------------------------------------------------------------------------
// device index, taken from host address bits 19..15
// ------------------------------------------------------------------------
`define HID_DEV_MOUSE 5
`define HID_DEV_KEYB 6

// event queue depth, both devices
`define HID_FIFO_DEPTH 8

// sys clocks without a ps/2 clock fall before a partial frame is dropped
`define PS2_IDLE_CYCLES 4096

`define PTR_MAX 1023 // highest pointer coordinate

`endif

//--- verilog/hid_bus_pkg.sv
package hid_bus_pkg;

   // ------------------------------------------------------------------------
   // host side of the hid block, single master
   // ------------------------------------------------------------------------

   typedef logic [19:0] hid_addr_t; // byte address, device in 19..15
   typedef logic [63:0] hid_data_t; // read and write data word
   typedef logic [7:0]  hid_be_t;   // byte enables, zero means read

   // one request per cycle, qualified by en
   // be == 0 reads, any be set writes
   typedef struct packed
   {
      logic      en;
      hid_be_t   be;
      hid_addr_t addr;
      hid_data_t wdata;
   } hid_req_t;

   // addr[14] picks the control space of a device
   // clear there needs all eight byte enables
   // wdata carries no meaning for pop or clear

endpackage

//--- verilog/hid_dev_pkg.sv
package hid_dev_pkg;

   typedef logic [7:0] scan_byte_t;  // one ps/2 data byte
   typedef logic [9:0] ptr_coord_t;  // pointer x or y

   // keyboard queue entry, 9 bits
   typedef struct packed
   {
      logic       released;  // code came after an f0 prefix
      scan_byte_t code;
   } key_event_t;

   // mouse queue entry, 23 bits
   typedef struct packed
   {
      logic       left;
      logic       middle;
      logic       right;
      ptr_coord_t y;
      ptr_coord_t x;
   } mouse_event_t;

   // ------------------------------------------------------------------------
   // host read words, lsb first in the order the host sees them
   // ------------------------------------------------------------------------
   typedef struct packed
   {
      logic [51:0] pad;
      logic        overflow;    // bit 11
      logic        frame_error; // bit 10
      logic        empty;       // bit 9
      logic        released;    // bit 8
      scan_byte_t  code;        // bits 7..0
   } key_status_t;

   typedef struct packed
   {
      logic [38:0] pad;
      logic        overflow;  // bit 24
      logic        empty;     // bit 23
      logic        right;     // bit 22
      logic        middle;    // bit 21
      logic        left;      // bit 20
      ptr_coord_t  y;         // bits 19..10
      ptr_coord_t  x;         // bits 9..0
   } mouse_status_t;

   // receiver frame position
   typedef enum logic [1:0]
   {
      ps2_idle,
      ps2_data,
      ps2_parity,
      ps2_stop
   } ps2_state_e;

endpackage

//--- verilog/ps2_rx.sv
`include "hid_consts.svh"

module ps2_rx
   import hid_dev_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       ps2_clk_i,    // async, from the device
   input  logic       ps2_data_i,
   output scan_byte_t byte_o,
   output logic       byte_valid_o, // one cycle per good frame
   output logic       frame_err_o   // one cycle per bad frame
);

   localparam int unsigned idle_w = $clog2(`PS2_IDLE_CYCLES);
   localparam logic [idle_w-1:0] idle_max = idle_w'(`PS2_IDLE_CYCLES - 1);

   logic [1:0]        clk_sync;
   logic [1:0]        data_sync;
   logic              clk_prev;
   logic              ps2_fall;    // falling edge of the synced ps/2 clock
   logic              ps2_bit;     // data as seen at that edge
   ps2_state_e        state;
   logic [2:0]        bit_cnt;
   logic              parity_acc;
   logic              parity_ok;
   logic [idle_w-1:0] idle_cnt;
   scan_byte_t        shift_q;

   // ------------------------------------------------------------------------
   // synchronisers, both lines idle high
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end
      else
      begin
         clk_sync  <= {clk_sync[0], ps2_clk_i};
         data_sync <= {data_sync[0], ps2_data_i};
         clk_prev  <= clk_sync[1];
      end
   end

   assign ps2_fall = clk_prev & ~clk_sync[1];
   assign ps2_bit  = data_sync[1]; // same depth as the clock path

   // ------------------------------------------------------------------------
   // frame fsm
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state        <= ps2_idle;
         bit_cnt      <= '0;
         parity_acc   <= 1'b0;
         parity_ok    <= 1'b0;
         idle_cnt     <= '0;
         byte_valid_o <= 1'b0;
         frame_err_o  <= 1'b0;
      end
      else
      begin
         byte_valid_o <= 1'b0;
         frame_err_o  <= 1'b0;
         if (ps2_fall || state == ps2_idle)
            idle_cnt <= '0;
         else
            idle_cnt <= idle_cnt + 1'b1;

         if (state != ps2_idle && !ps2_fall && idle_cnt == idle_max)
            state <= ps2_idle; // device went quiet mid frame
         else if (ps2_fall)
         begin
            case (state)
               ps2_idle:
               begin
                  if (!ps2_bit) // start bit
                  begin
                     state      <= ps2_data;
                     bit_cnt    <= '0;
                     parity_acc <= 1'b0;
                  end
               end
               ps2_data:
               begin
                  parity_acc <= parity_acc ^ ps2_bit;
                  bit_cnt    <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state <= ps2_parity;
               end
               ps2_parity:
               begin
                  parity_ok <= parity_acc ^ ps2_bit; // odd parity
                  state     <= ps2_stop;
               end
               default:
               begin
                  if (ps2_bit && parity_ok)
                     byte_valid_o <= 1'b1;
                  else
                     frame_err_o <= 1'b1; // frame thrown away
                  state <= ps2_idle;
               end
            endcase
         end
      end
   end

   // data bits come lsb first
   always_ff @(posedge clk_i)
   begin
      if (ps2_fall && state == ps2_data)
         shift_q <= {ps2_bit, shift_q[7:1]};
   end

   assign byte_o = shift_q;

   a_valid_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
      !(byte_valid_o && frame_err_o));

endmodule

//--- verilog/key_decoder.sv
module key_decoder
   import hid_dev_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  scan_byte_t byte_i,
   input  logic       byte_valid_i,
   output key_event_t event_o,
   output logic       event_valid_o
);

   localparam scan_byte_t break_code = 8'hF0;

   logic release_pend; // f0 seen, next code is a release

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         release_pend  <= 1'b0;
         event_valid_o <= 1'b0;
      end
      else
      begin
         event_valid_o <= 1'b0;
         if (byte_valid_i)
         begin
            if (byte_i == break_code)
               release_pend <= 1'b1; // prefix only, no event
            else
            begin
               event_valid_o <= 1'b1;
               release_pend  <= 1'b0;
            end
         end
      end
   end

   // payload, only meaningful with event_valid_o
   always_ff @(posedge clk_i)
   begin
      if (byte_valid_i && byte_i != break_code)
         event_o <= '{released: release_pend, code: byte_i};
   end

endmodule

//--- verilog/mouse_packet.sv
`include "hid_consts.svh"

module mouse_packet
   import hid_dev_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic         clear_i,      // host clear, zero position
   input  scan_byte_t   byte_i,
   input  logic         byte_valid_i,
   output mouse_event_t event_o,
   output logic         event_valid_o
);

   logic [1:0] byte_idx;  // 0..2 within the packet
   scan_byte_t hdr_q;     // buttons and sign bits
   scan_byte_t dx_q;      // low byte of x delta
   ptr_coord_t pos_x;
   ptr_coord_t pos_y;
   ptr_coord_t next_x;
   ptr_coord_t next_y;

   // position plus 9-bit signed delta, clamped to 0..PTR_MAX
   function automatic ptr_coord_t sat_add(ptr_coord_t pos, logic sign, scan_byte_t lo);
      logic signed [11:0] sum;
      sum = $signed({2'b00, pos}) + $signed({{3{sign}}, sign, lo});
      if (sum < 0)
         return '0;
      else if (sum > `PTR_MAX)
         return ptr_coord_t'(`PTR_MAX);
      else
         return sum[9:0];
   endfunction

   assign next_x = sat_add(pos_x, hdr_q[4], dx_q);
   assign next_y = sat_add(pos_y, hdr_q[5], byte_i); // y is the third byte

   always_ff @(posedge clk_i)
   begin
      if (rst_i || clear_i)
      begin
         byte_idx      <= '0;
         pos_x         <= '0;
         pos_y         <= '0;
         event_valid_o <= 1'b0;
      end
      else
      begin
         event_valid_o <= 1'b0;
         if (byte_valid_i)
         begin
            case (byte_idx)
               2'd0:
               begin
                  if (byte_i[3]) // always-one bit, else out of sync
                     byte_idx <= 2'd1;
               end
               2'd1:    byte_idx <= 2'd2;
               default:
               begin
                  byte_idx      <= '0;
                  pos_x         <= next_x;
                  pos_y         <= next_y;
                  event_valid_o <= 1'b1;
               end
            endcase
         end
      end
   end

   // payload regs
   always_ff @(posedge clk_i)
   begin
      if (byte_valid_i && byte_idx == 2'd0)
         hdr_q <= byte_i;
      if (byte_valid_i && byte_idx == 2'd1)
         dx_q <= byte_i;
      if (byte_valid_i && byte_idx == 2'd2)
         event_o <= '{left: hdr_q[0], middle: hdr_q[2], right: hdr_q[1],
                      y: next_y, x: next_x};
   end

endmodule

//--- verilog/event_fifo.sv
`include "hid_consts.svh"

module event_fifo #(
   parameter int unsigned WIDTH = 9,
   parameter int unsigned DEPTH = `HID_FIFO_DEPTH
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             clear_i,
   input  logic             push_i,
   input  logic             pop_i,
   input  logic [WIDTH-1:0] data_i,
   output logic [WIDTH-1:0] data_o,     // head, valid when not empty
   output logic             empty_o,
   output logic             overflow_o  // sticky, reset or clear only
);

   localparam int unsigned ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned cnt_w = $clog2(DEPTH + 1);
   localparam logic [ptr_w-1:0] last_ptr = ptr_w'(DEPTH - 1);
   localparam logic [cnt_w-1:0] depth_c  = cnt_w'(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             full;
   logic             do_push;
   logic             do_pop;

   assign full    = (count == depth_c);
   assign empty_o = (count == '0);
   assign do_pop  = pop_i & ~empty_o;           // pop on empty ignored
   assign do_push = push_i & (~full | do_pop);  // full + pop frees a slot
   assign data_o  = mem[rd_ptr];

   always_ff @(posedge clk_i)
   begin
      if (rst_i || clear_i)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         overflow_o <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
         if (push_i && !do_push)
            overflow_o <= 1'b1; // event lost
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (do_push)
         mem[wr_ptr] <= data_i;
   end

   a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      count <= depth_c);

endmodule

//--- verilog/hid_regs.sv
`include "hid_consts.svh"

module hid_regs
   import hid_bus_pkg::*, hid_dev_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_i,
   input  hid_req_t     req_i,
   output hid_data_t    rdata_o,       // one cycle after a read, else 0
   // keyboard
   input  key_event_t   key_head_i,
   input  logic         key_empty_i,
   input  logic         key_err_i,     // receiver error pulse
   input  logic         key_ovf_i,
   output logic         key_pop_o,
   // mouse
   input  mouse_event_t mouse_head_i,
   input  logic         mouse_empty_i,
   input  logic         mouse_ovf_i,
   output logic         mouse_pop_o,
   output logic         mouse_clear_o
);

   localparam logic [4:0] dev_keyb  = 5'(`HID_DEV_KEYB);
   localparam logic [4:0] dev_mouse = 5'(`HID_DEV_MOUSE);

   logic [1:0]    dev_sel;  // {keyb, mouse}
   logic          is_read;
   logic          is_write;
   logic          frame_err_q;
   key_status_t   key_word;
   mouse_status_t mouse_word;

   // ------------------------------------------------------------------------
   // decode
   // ------------------------------------------------------------------------
   assign dev_sel[0] = (req_i.addr[19:15] == dev_mouse);
   assign dev_sel[1] = (req_i.addr[19:15] == dev_keyb);
   assign is_read    = req_i.en & (req_i.be == '0);
   assign is_write   = req_i.en & (|req_i.be);

   assign key_pop_o     = is_write & dev_sel[1] & ~req_i.addr[14];
   assign mouse_pop_o   = is_write & dev_sel[0] & ~req_i.addr[14];
   assign mouse_clear_o = is_write & dev_sel[0] & req_i.addr[14] & (&req_i.be);

   // kbd error stays up until reset
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         frame_err_q <= 1'b0;
      else if (key_err_i)
         frame_err_q <= 1'b1;
   end

   // ------------------------------------------------------------------------
   // status words from the fifo heads
   // ------------------------------------------------------------------------
   always_comb
   begin
      key_word             = '0;
      key_word.code        = key_head_i.code;
      key_word.released    = key_head_i.released;
      key_word.empty       = key_empty_i;
      key_word.frame_error = frame_err_q;
      key_word.overflow    = key_ovf_i;

      mouse_word          = '0;
      mouse_word.x        = mouse_head_i.x;
      mouse_word.y        = mouse_head_i.y;
      mouse_word.left     = mouse_head_i.left;
      mouse_word.middle   = mouse_head_i.middle;
      mouse_word.right    = mouse_head_i.right;
      mouse_word.empty    = mouse_empty_i;
      mouse_word.overflow = mouse_ovf_i;
   end

   // registered one-hot read mux, unmapped index reads 0
   always_ff @(posedge clk_i)
   begin
      if (rst_i || !is_read)
         rdata_o <= '0;
      else
         rdata_o <= ({64{dev_sel[1]}} & hid_data_t'(key_word))
                  | ({64{dev_sel[0]}} & hid_data_t'(mouse_word));
   end

   a_sel_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(dev_sel));

endmodule

//--- verilog/hid_soc.sv
module hid_soc
   import hid_bus_pkg::*, hid_dev_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      key_clk_i,    // keyboard ps/2
   input  logic      key_data_i,
   input  logic      mouse_clk_i,  // mouse ps/2
   input  logic      mouse_data_i,
   input  hid_req_t  req_i,
   output hid_data_t rdata_o
);

   scan_byte_t   key_byte, mouse_byte;
   logic         key_byte_vld, mouse_byte_vld;
   logic         key_err;
   key_event_t   key_ev, key_head;
   logic         key_ev_vld, key_empty, key_ovf, key_pop;
   mouse_event_t mouse_ev, mouse_head;
   logic         mouse_ev_vld, mouse_empty, mouse_ovf, mouse_pop, mouse_clear;

   // ------------------------------------------------------------------------
   // keyboard path
   // ------------------------------------------------------------------------
   ps2_rx u_key_rx (.clk_i, .rst_i, .ps2_clk_i(key_clk_i), .ps2_data_i(key_data_i),
      .byte_o(key_byte), .byte_valid_o(key_byte_vld), .frame_err_o(key_err));

   key_decoder u_key_dec (.clk_i, .rst_i, .byte_i(key_byte), .byte_valid_i(key_byte_vld),
      .event_o(key_ev), .event_valid_o(key_ev_vld));

   event_fifo #(.WIDTH($bits(key_event_t))) u_key_fifo (.clk_i, .rst_i, .clear_i(1'b0),
      .push_i(key_ev_vld), .pop_i(key_pop), .data_i(key_ev), .data_o(key_head),
      .empty_o(key_empty), .overflow_o(key_ovf));

   // ------------------------------------------------------------------------
   // mouse path, error of this receiver is not reported
   // ------------------------------------------------------------------------
   ps2_rx u_mouse_rx (.clk_i, .rst_i, .ps2_clk_i(mouse_clk_i), .ps2_data_i(mouse_data_i),
      .byte_o(mouse_byte), .byte_valid_o(mouse_byte_vld), .frame_err_o());

   mouse_packet u_mouse_pkt (.clk_i, .rst_i, .clear_i(mouse_clear), .byte_i(mouse_byte),
      .byte_valid_i(mouse_byte_vld), .event_o(mouse_ev), .event_valid_o(mouse_ev_vld));

   event_fifo #(.WIDTH($bits(mouse_event_t))) u_mouse_fifo (.clk_i, .rst_i,
      .clear_i(mouse_clear), .push_i(mouse_ev_vld), .pop_i(mouse_pop), .data_i(mouse_ev),
      .data_o(mouse_head), .empty_o(mouse_empty), .overflow_o(mouse_ovf));

   // host registers
   hid_regs u_regs (.clk_i, .rst_i, .req_i, .rdata_o,
      .key_head_i(key_head), .key_empty_i(key_empty), .key_err_i(key_err),
      .key_ovf_i(key_ovf), .key_pop_o(key_pop),
      .mouse_head_i(mouse_head), .mouse_empty_i(mouse_empty), .mouse_ovf_i(mouse_ovf),
      .mouse_pop_o(mouse_pop), .mouse_clear_o(mouse_clear));

endmodule

//--- verif/tb_hid_soc.sv
`include "hid_consts.svh"

module tb_hid_soc
   import hid_bus_pkg::*, hid_dev_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_ns       = 4;
   localparam int bit_cycles   = 40;  // ps/2 bit period in clk_i cycles
   localparam int gap_cycles   = 20;  // idle time after each frame
   localparam int frame_cycles = 11 * bit_cycles + gap_cycles;
   localparam int depth        = `HID_FIFO_DEPTH;

   typedef enum logic [2:0] {k_keys, k_mouse, k_badpar, k_burst, k_clear} kind_e;

   // one table row, bytes go out from b[0] up
   typedef struct packed
   {
      kind_e           kind;
      logic [3:0]      n;          // bytes in use
      logic [8:0][7:0] b;
      key_status_t     key_exp;    // flags only, events come from the bytes
      mouse_status_t   mouse_exp;  // head word once the frames are in
   } stim_t;

   logic       clk_i = 1'b0;
   logic       rst_i;
   logic       key_clk_i, key_data_i;
   logic       mouse_clk_i, mouse_data_i;
   hid_req_t   req_i;
   hid_data_t  rdata_o;
   stim_t      tab[$];
   logic       tab_ready = 1'b0;
   key_event_t exp_keys[$];   // events expected from one key entry
   integer     seed;
   int         mx;            // model pointer position
   int         my;
   logic       err_seen;      // model sticky flags
   logic       ovf_seen;

   hid_soc hid_soc_i (.clk_i, .rst_i, .key_clk_i, .key_data_i, .mouse_clk_i,
      .mouse_data_i, .req_i, .rdata_o);

   initial
   begin
      forever #(clk_ns / 2) clk_i = ~clk_i;
   end

   // ------------------------------------------------------------------------
   // ps/2 side
   // ------------------------------------------------------------------------
   task automatic set_pins(input logic to_mouse, input logic pclk, input logic pdata);
      if (to_mouse)
      begin
         mouse_clk_i  = pclk;
         mouse_data_i = pdata;
      end
      else
      begin
         key_clk_i  = pclk;
         key_data_i = pdata;
      end
   endtask

   // start, 8 data lsb first, odd parity, stop
   task automatic send_frame(input logic to_mouse, input scan_byte_t data, input logic bad_par);
      logic [10:0] frame;
      int          i;
      frame = {1'b1, ~(^data) ^ bad_par, data, 1'b0};
      for (i = 0; i < 11; i++)
      begin
         @(negedge clk_i);
         set_pins(to_mouse, 1'b1, frame[i]);   // data settles while clock high
         repeat (bit_cycles / 4) @(negedge clk_i);
         set_pins(to_mouse, 1'b0, frame[i]);   // device samples here
         repeat (bit_cycles / 2) @(negedge clk_i);
         set_pins(to_mouse, 1'b1, frame[i]);
         repeat (bit_cycles / 4 - 1) @(negedge clk_i);
      end
      repeat (gap_cycles) @(negedge clk_i);
   endtask

   // ------------------------------------------------------------------------
   // host bus
   // ------------------------------------------------------------------------
   function automatic hid_req_t make_req(input hid_be_t be, input int dev, input logic ctrl);
      hid_req_t r;
      r       = '0;
      r.en    = 1'b1;
      r.be    = be;
      r.addr  = {5'(dev), ctrl, 14'h0};
      return r;
   endfunction

   task automatic read_word(input int dev, output hid_data_t data);
      @(negedge clk_i);
      req_i = make_req(8'h00, dev, 1'b0);
      @(negedge clk_i);
      req_i = '0;
      data  = rdata_o; // registered at the edge after the request
   endtask

   task automatic pop(input int dev);
      @(negedge clk_i);
      req_i = make_req(8'h01, dev, 1'b0);
      @(negedge clk_i);
      req_i = '0;
      check_word(rdata_o, "read data after a pop"); // a write returns nothing
   endtask

   task automatic clear(input int dev);
      @(negedge clk_i);
      req_i = make_req(8'hFF, dev, 1'b1); // control space, all lanes
      @(negedge clk_i);
      req_i = '0;
      check_word(rdata_o, "read data after a clear");
   endtask

   // ------------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------------
   task automatic report_mismatch(input string what, input string field,
                                  input logic [63:0] got, input logic [63:0] exp);
      $display("FAIL %0t ns: %s, %s is 0x%0h, expected 0x%0h", $time, what, field, got, exp);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
   endtask

   // code and released only count when the queue holds something
   task automatic check_key(input key_status_t got, input key_status_t exp, input string what);
      if (got.empty !== exp.empty)
         report_mismatch(what, "empty", 64'(got.empty), 64'(exp.empty));
      else if (got.frame_error !== exp.frame_error)
         report_mismatch(what, "frame_error", 64'(got.frame_error), 64'(exp.frame_error));
      else if (got.overflow !== exp.overflow)
         report_mismatch(what, "overflow", 64'(got.overflow), 64'(exp.overflow));
      else if (!exp.empty && got.code !== exp.code)
         report_mismatch(what, "code", 64'(got.code), 64'(exp.code));
      else if (!exp.empty && got.released !== exp.released)
         report_mismatch(what, "released", 64'(got.released), 64'(exp.released));
      else if (got.pad !== '0)
         report_mismatch(what, "upper bits", 64'(got.pad), 64'(0));
   endtask

   task automatic check_mouse(input mouse_status_t got, input mouse_status_t exp,
                              input string what);
      if (got.empty !== exp.empty)
         report_mismatch(what, "empty", 64'(got.empty), 64'(exp.empty));
      else if (got.overflow !== exp.overflow)
         report_mismatch(what, "overflow", 64'(got.overflow), 64'(exp.overflow));
      else if (!exp.empty && got.x !== exp.x)
         report_mismatch(what, "x", 64'(got.x), 64'(exp.x));
      else if (!exp.empty && got.y !== exp.y)
         report_mismatch(what, "y", 64'(got.y), 64'(exp.y));
      else if (!exp.empty && {got.left, got.middle, got.right} !==
               {exp.left, exp.middle, exp.right})
         report_mismatch(what, "buttons l/m/r", 64'({got.left, got.middle, got.right}),
                         64'({exp.left, exp.middle, exp.right}));
      else if (got.pad !== '0)
         report_mismatch(what, "upper bits", 64'(got.pad), 64'(0));
   endtask

   task automatic check_word(input hid_data_t got, input string what);
      if (got !== '0)
         report_mismatch(what, "word", got, 64'(0));
   endtask

   // ------------------------------------------------------------------------
   // reference model and table
   // ------------------------------------------------------------------------
   function automatic int clamp(input int v);
      if (v < 0)
         return 0;
      else if (v > `PTR_MAX)
         return `PTR_MAX;
      else
         return v;
   endfunction

   function automatic int rand_delta();
      return $random(seed) % 256; // -255..255, fits the 9-bit delta
   endfunction

   // first byte of bytes sits in bits 71..64
   function automatic stim_t key_entry(input kind_e kind, input logic [71:0] bytes, input int n);
      stim_t s;
      int    i;
      s      = '0;
      s.kind = kind;
      s.n    = 4'(n);
      for (i = 0; i < n; i++)
         s.b[i] = bytes[71 - 8 * i -: 8];
      if (kind == k_badpar)
         err_seen = 1'b1;
      if (kind == k_burst)
         ovf_seen = 1'b1;  // keyboard queue has no clear
      s.key_exp.frame_error = err_seen;
      s.key_exp.overflow    = ovf_seen;
      return s;
   endfunction

   // btn is {middle, right, left} as in the header byte
   function automatic stim_t mouse_entry(input int dx, input int dy, input logic [2:0] btn,
                                         input logic junk);
      stim_t      s;
      scan_byte_t hdr;
      int         o;
      s      = '0;
      s.kind = k_mouse;
      o      = junk ? 1 : 0;
      hdr    = {2'b00, dy < 0, dx < 0, 1'b1, btn};
      s.b[0] = 8'h37;            // bit 3 clear, out of sync byte
      s.b[o] = hdr;
      s.b[o + 1] = 8'(dx);
      s.b[o + 2] = 8'(dy);
      s.n    = 4'(3 + o);
      mx     = clamp(mx + dx);   // running position, clamped each packet
      my     = clamp(my + dy);
      s.mouse_exp.x      = 10'(mx);
      s.mouse_exp.y      = 10'(my);
      s.mouse_exp.left   = btn[0];
      s.mouse_exp.right  = btn[1];
      s.mouse_exp.middle = btn[2];
      return s;
   endfunction

   task automatic build_table();
      stim_t      s;
      int         i;
      int         dx;
      int         dy;
      logic [2:0] btn;
      tab.push_back(key_entry(k_keys, {8'h1C, 8'hF0, 8'h1C, 48'h0}, 3));
      tab.push_back(key_entry(k_badpar, {8'h5A, 8'h32, 56'h0}, 2));
      tab.push_back(mouse_entry(100, 50, 3'b001, 1'b0));
      tab.push_back(mouse_entry(-30, -80, 3'b010, 1'b0));   // y hits 0
      tab.push_back(mouse_entry(-200, 255, 3'b100, 1'b0));  // x hits 0
      for (i = 0; i < 5; i++)
      begin
         dy  = rand_delta();
         btn = 3'($random(seed));
         tab.push_back(mouse_entry(255, dy, btn, 1'b0));     // x runs into the top
      end
      for (i = 0; i < 3; i++)
      begin
         dx  = rand_delta();
         dy  = rand_delta();
         btn = 3'($random(seed));
         tab.push_back(mouse_entry(dx, dy, btn, 1'b0));
      end
      tab.push_back(mouse_entry(-40, 60, 3'b011, 1'b1));     // junk byte first
      s      = mouse_entry(17, 9, 3'b101, 1'b0);             // queue overrun, then cleared
      s.kind = k_clear;
      s.mouse_exp.overflow = 1'b1; // head is the first of the repeated packets
      mx = 0;
      my = 0;
      tab.push_back(s);
      tab.push_back(mouse_entry(0, 0, 3'b000, 1'b0));        // position back at 0
      tab.push_back(key_entry(k_burst, {8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C, 8'h35,
                                        8'h3C, 8'h43, 8'h44}, 9));
   endtask

   // f0 marks the next code released, events past the depth are lost
   function automatic void expect_keys(input stim_t s);
      logic pend;
      int   i;
      pend = 1'b0;
      exp_keys.delete();
      for (i = (s.kind == k_badpar) ? 1 : 0; i < int'(s.n); i++)
      begin
         if (s.b[i] == 8'hF0)
            pend = 1'b1;
         else
         begin
            if (int'(exp_keys.size()) < depth)
               exp_keys.push_back(key_event_t'{released: pend, code: s.b[i]});
            pend = 1'b0;
         end
      end
   endfunction

   // ------------------------------------------------------------------------
   // entry runners
   // ------------------------------------------------------------------------
   task automatic run_keys(input stim_t s);
      hid_data_t   rd;
      key_status_t exp;
      int          i;
      for (i = 0; i < int'(s.n); i++)
         send_frame(1'b0, s.b[i], s.kind == k_badpar && i == 0);
      expect_keys(s);
      exp       = s.key_exp;
      exp.empty = 1'b0;
      foreach (exp_keys[k])
      begin
         exp.code     = exp_keys[k].code;
         exp.released = exp_keys[k].released;
         read_word(`HID_DEV_KEYB, rd);
         check_key(key_status_t'(rd), exp, "key head");
         read_word(`HID_DEV_KEYB, rd);  // no pop yet, same head
         check_key(key_status_t'(rd), exp, "key head reread");
         pop(`HID_DEV_KEYB);
      end
      exp.empty = 1'b1;
      read_word(`HID_DEV_KEYB, rd);
      check_key(key_status_t'(rd), exp, "key queue drained");
   endtask

   task automatic run_mouse(input stim_t s);
      hid_data_t     rd;
      mouse_status_t exp;
      int            reps;
      int            r;
      int            i;
      reps = (s.kind == k_clear) ? depth + 1 : 1; // one packet past a full queue
      for (r = 0; r < reps; r++)
      begin
         for (i = 0; i < int'(s.n); i++)
            send_frame(1'b1, s.b[i], 1'b0);
      end
      exp = s.mouse_exp;
      read_word(`HID_DEV_MOUSE, rd);
      check_mouse(mouse_status_t'(rd), exp, "mouse head");
      if (s.kind == k_clear)
      begin
         clear(`HID_DEV_MOUSE);
         exp       = '0;
         exp.empty = 1'b1; // events and overflow gone
         read_word(`HID_DEV_MOUSE, rd);
         check_mouse(mouse_status_t'(rd), exp, "mouse cleared");
      end
      else
      begin
         pop(`HID_DEV_MOUSE);
         exp.empty = 1'b1;
         read_word(`HID_DEV_MOUSE, rd);
         check_mouse(mouse_status_t'(rd), exp, "mouse queue drained");
      end
   endtask

   // ------------------------------------------------------------------------
   // main sequence and watchdog
   // ------------------------------------------------------------------------
   initial
   begin
      hid_data_t rd;
      int        i;
      seed         = 98;
      rst_i        = 1'b1;
      req_i        = '0;
      key_clk_i    = 1'b1;  // ps/2 lines idle high
      key_data_i   = 1'b1;
      mouse_clk_i  = 1'b1;
      mouse_data_i = 1'b1;
      mx           = 0;
      my           = 0;
      err_seen     = 1'b0;
      ovf_seen     = 1'b0;
      build_table();
      tab_ready = 1'b1;
      repeat (4) @(negedge clk_i);
      rst_i = 1'b0;
      check_word(rdata_o, "read data out of reset");

      read_word(0, rd);
      check_word(rd, "unmapped index 0");
      read_word(7, rd);
      check_word(rd, "unmapped index 7");

      for (i = 0; i < int'(tab.size()); i++)
      begin
         if (tab[i].kind == k_mouse || tab[i].kind == k_clear)
            run_mouse(tab[i]);
         else
            run_keys(tab[i]);
      end

      read_word(31, rd);
      check_word(rd, "unmapped index 31");
      $display("Verification passed");
      $finish;
   end

   // the table averages far fewer than 12 frames per entry
   initial
   begin
      longint limit_ns;
      wait (tab_ready);
      limit_ns = longint'(tab.size()) * frame_cycles * clk_ns * 12 + 20000;
      #(limit_ns);
      $display("timeout: the tests did not finish within %0d ns", limit_ns);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- files.f
+incdir+verilog
verilog/hid_bus_pkg.sv
verilog/hid_dev_pkg.sv
verilog/ps2_rx.sv
verilog/key_decoder.sv
verilog/mouse_packet.sv
verilog/event_fifo.sv
verilog/hid_regs.sv
verilog/hid_soc.sv
verif/tb_hid_soc.sv

//--- run.sh
#!/bin/sh
# build and run the hid_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_hid_soc \
   -Mdir obj_dir -o tb_hid_soc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/tb_hid_soc_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi
exit 0
